// File: logic/mem_arb_pkg.sv
package mem_arb_pkg;

  // ----------------------------------------
  // save-RAM geometry
  // ----------------------------------------
  localparam int unsigned addr_w = 19;  // 4 Mbit SRAM, byte wide
  localparam int unsigned data_w = 8;

  // access timer width, holds cycle lengths up to 15
  localparam int unsigned timer_w = 4;

  // newest synchronizer stages skipped by the edge detector
  localparam int unsigned sync_skip = 1;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_t;

  // access states are split per requester
  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_cop_access = 2'd1,
    st_mcu_access = 2'd2,
    st_end        = 2'd3
  } arb_state_t;

  // RAM owner, none outside the access states
  typedef enum logic [1:0] {
    grant_none = 2'd0,
    grant_cop  = 2'd1,
    grant_mcu  = 2'd2
  } grant_t;

endpackage

// File: logic/slot_if.sv
`timescale 1ns/1ps

interface slot_if import mem_arb_pkg::*; ();

  // request side, held by the slot until done
  logic                pending;
  mem_op_t             op;
  logic [addr_w-1:0]   addr;
  logic [data_w-1:0]   wdata;

  // completion side
  logic                done;   // one cycle in st_end
  logic [data_w-1:0]   rdata;  // last sample of the access

  modport slot (
    output pending, op, addr, wdata,
    input  done, rdata
  );

  modport arbiter (
    input  pending,
    output done
  );

  modport datapath (
    input  op, addr, wdata,
    output rdata
  );

endinterface

// File: logic/cycle_sync.sv
`timescale 1ns/1ps

module cycle_sync import mem_arb_pkg::*; #(
  parameter int unsigned SYNC_DEPTH = 7
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic snes_cpu_clk,
  input  logic snes_ram_hit,
  output logic free
);

  localparam int unsigned win_w = SYNC_DEPTH - sync_skip;

  logic [SYNC_DEPTH-1:0] cpu_clk_sr;   // bit 0 is the newest sample
  logic [win_w-1:0]      win;
  logic                  cycle_start;
  logic                  cycle_end;

  // ----------------------------------------
  // cpu clock synchronizer
  // ----------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cpu_clk_sr <= '0;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  assign win = cpu_clk_sr[SYNC_DEPTH-1:sync_skip];

  // a run of old samples, then one new sample of the other level
  assign cycle_start = (win == {{(win_w-1){1'b0}}, 1'b1});
  assign cycle_end   = (win == {{(win_w-1){1'b1}}, 1'b0});

  // ----------------------------------------
  // free slot strobe
  // ----------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free <= 1'b0;
    end else begin
      // cycle start only counts when the console leaves save RAM alone
      free <= cycle_end | (cycle_start & ~snes_ram_hit);
    end
  end

endmodule

// File: logic/request_slot.sv
`timescale 1ns/1ps

module request_slot import mem_arb_pkg::*; (
  input  logic              CLK2,
  input  logic              rst_n,
  input  logic              req,
  input  logic              write,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  output logic              credit,
  output logic [data_w-1:0] rdata,
  slot_if.slot              bus
);

  logic              pending_q;
  logic              credit_held_q;  // one credit per requester
  logic              credit_q;
  mem_op_t           op_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [data_w-1:0] rdata_q;

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      pending_q     <= 1'b0;
      credit_held_q <= 1'b1;
      credit_q      <= 1'b0;
    end else begin
      credit_q <= 1'b0;  // pulse only
      if (bus.done) begin
        pending_q     <= 1'b0;
        credit_held_q <= 1'b1;
        credit_q      <= 1'b1;
      end else if (req && credit_held_q) begin
        pending_q     <= 1'b1;
        credit_held_q <= 1'b0;  // spent until the access ends
      end
    end
  end

  // request payload and returned data
  always_ff @(posedge CLK2) begin
    if (req && credit_held_q) begin
      op_q    <= write ? op_write : op_read;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (bus.done) begin
      rdata_q <= bus.rdata;  // valid with the credit pulse
    end
  end

  assign bus.pending = pending_q;
  assign bus.op      = op_q;
  assign bus.addr    = addr_q;
  assign bus.wdata   = wdata_q;

  assign credit = credit_q;
  assign rdata  = rdata_q;

endmodule

// File: logic/access_timer.sv
`timescale 1ns/1ps

module access_timer import mem_arb_pkg::*; #(
  parameter int unsigned CYCLE_LEN = 5
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic load,
  output logic expired
);

  logic [timer_w-1:0] cnt_q;

  // counts CYCLE_LEN down to 0, so an access spans CYCLE_LEN+1 cycles
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= timer_w'(CYCLE_LEN);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign expired = (cnt_q == '0);  // parks at zero when idle

endmodule

// File: logic/ram_arbiter_fsm.sv
`timescale 1ns/1ps

module ram_arbiter_fsm import mem_arb_pkg::*; (
  input  logic   CLK2,
  input  logic   rst_n,
  input  logic   free,
  input  logic   expired,
  output logic   load,
  output grant_t grant,
  slot_if.arbiter cop,
  slot_if.arbiter mcu
);

  arb_state_t state_q;
  arb_state_t state_d;
  grant_t     owner_q;  // who gets done in st_end
  logic       start;

  // new access only in a free slot
  assign start = (state_q == st_idle) && free && (cop.pending || mcu.pending);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (free) begin
          if (cop.pending) begin
            state_d = st_cop_access;  // coprocessor wins a shared slot
          end else if (mcu.pending) begin
            state_d = st_mcu_access;
          end
        end
      end
      st_cop_access, st_mcu_access: begin
        if (expired) begin
          state_d = st_end;
        end
      end
      st_end: begin
        state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state_q <= st_idle;
      owner_q <= grant_none;
    end else begin
      state_q <= state_d;
      if (start) begin
        owner_q <= cop.pending ? grant_cop : grant_mcu;
      end
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign load = start;

  always_comb begin
    case (state_q)
      st_cop_access: grant = grant_cop;
      st_mcu_access: grant = grant_mcu;
      default:       grant = grant_none;  // idle and end cycles
    endcase
  end

  assign cop.done = (state_q == st_end) && (owner_q == grant_cop);
  assign mcu.done = (state_q == st_end) && (owner_q == grant_mcu);

endmodule

// File: logic/ram_data_path.sv
`timescale 1ns/1ps

module ram_data_path import mem_arb_pkg::*; (
  input  logic              CLK2,
  input  logic              rst_n,
  input  grant_t            grant,
  slot_if.datapath          cop,
  slot_if.datapath          mcu,
  output logic [addr_w-1:0] ram_addr,
  output logic [data_w-1:0] ram_wdata,
  output logic              ram_we,
  input  logic [data_w-1:0] ram_rdata
);

  logic cop_wr;
  logic mcu_wr;

  assign cop_wr = (grant == grant_cop) && (cop.op == op_write);
  assign mcu_wr = (grant == grant_mcu) && (mcu.op == op_write);

  // ----------------------------------------
  // RAM side
  // ----------------------------------------
  // coprocessor address parks on the bus when nobody owns it
  assign ram_addr  = (grant == grant_mcu) ? mcu.addr  : cop.addr;
  assign ram_wdata = (grant == grant_mcu) ? mcu.wdata : cop.wdata;
  assign ram_we    = ~(cop_wr | mcu_wr);  // active low, whole access

  // ----------------------------------------
  // read capture
  // ----------------------------------------
  // sampled every granted cycle, last one stands at st_end
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cop.rdata <= '0;
      mcu.rdata <= '0;
    end else begin
      if (grant == grant_cop) begin
        cop.rdata <= ram_rdata;
      end
      if (grant == grant_mcu) begin
        mcu.rdata <= ram_rdata;
      end
    end
  end

endmodule

// File: logic/ram_arb_top.sv
`timescale 1ns/1ps

module ram_arb_top import mem_arb_pkg::*; #(
  parameter int unsigned CYCLE_LEN  = 5,
  parameter int unsigned SYNC_DEPTH = 7
) (
  input  logic              CLK2,
  input  logic              rst_n,
  // console
  input  logic              snes_cpu_clk,
  input  logic              snes_ram_hit,
  // coprocessor requester
  input  logic              cop_req,
  input  logic              cop_write,
  input  logic [addr_w-1:0] cop_addr,
  input  logic [data_w-1:0] cop_wdata,
  output logic              cop_credit,
  output logic [data_w-1:0] cop_rdata,
  // mcu requester
  input  logic              mcu_req,
  input  logic              mcu_write,
  input  logic [addr_w-1:0] mcu_addr,
  input  logic [data_w-1:0] mcu_wdata,
  output logic              mcu_credit,
  output logic [data_w-1:0] mcu_rdata,
  // save RAM
  output logic [addr_w-1:0] ram_addr,
  output logic [data_w-1:0] ram_wdata,
  output logic              ram_we,
  input  logic [data_w-1:0] ram_rdata
);

  logic   free;
  logic   load;
  logic   expired;
  grant_t grant;

  slot_if cop_bus ();
  slot_if mcu_bus ();

  // ----------------------------------------
  // console timing
  // ----------------------------------------
  cycle_sync #(
    .SYNC_DEPTH (SYNC_DEPTH)
  ) u_cycle_sync (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_ram_hit (snes_ram_hit),
    .free         (free)
  );

  // ----------------------------------------
  // request slots
  // ----------------------------------------
  request_slot u_cop_slot (
    .CLK2   (CLK2),
    .rst_n  (rst_n),
    .req    (cop_req),
    .write  (cop_write),
    .addr   (cop_addr),
    .wdata  (cop_wdata),
    .credit (cop_credit),
    .rdata  (cop_rdata),
    .bus    (cop_bus.slot)
  );

  request_slot u_mcu_slot (
    .CLK2   (CLK2),
    .rst_n  (rst_n),
    .req    (mcu_req),
    .write  (mcu_write),
    .addr   (mcu_addr),
    .wdata  (mcu_wdata),
    .credit (mcu_credit),
    .rdata  (mcu_rdata),
    .bus    (mcu_bus.slot)
  );

  // ----------------------------------------
  // arbitration and RAM access
  // ----------------------------------------
  access_timer #(
    .CYCLE_LEN (CYCLE_LEN)
  ) u_access_timer (
    .CLK2    (CLK2),
    .rst_n   (rst_n),
    .load    (load),
    .expired (expired)
  );

  ram_arbiter_fsm u_ram_arbiter_fsm (
    .CLK2    (CLK2),
    .rst_n   (rst_n),
    .free    (free),
    .expired (expired),
    .load    (load),
    .grant   (grant),
    .cop     (cop_bus.arbiter),
    .mcu     (mcu_bus.arbiter)
  );

  ram_data_path u_ram_data_path (
    .CLK2      (CLK2),
    .rst_n     (rst_n),
    .grant     (grant),
    .cop       (cop_bus.datapath),
    .mcu       (mcu_bus.datapath),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata)
  );

endmodule

// File: verification/ram_arb_sva.sv
`timescale 1ns/1ps

module ram_arb_sva import mem_arb_pkg::*; #(
  parameter int unsigned CYCLE_LEN = 5
) (
  input logic       CLK2,
  input logic       rst_n,
  input logic       ram_we,
  input arb_state_t state,
  input mem_op_t    cop_op,
  input mem_op_t    mcu_op,
  input logic       cop_req,
  input logic       cop_credit,
  input logic       mcu_req,
  input logic       mcu_credit
);

  logic        cop_held;  // credit model per requester
  logic        mcu_held;
  int unsigned cop_wait;
  int unsigned mcu_wait;

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cop_held <= 1'b1;
      mcu_held <= 1'b1;
      cop_wait <= 0;
      mcu_wait <= 0;
    end else begin
      if (cop_credit) cop_held <= 1'b1;
      else if (cop_req) cop_held <= 1'b0;
      if (mcu_credit) mcu_held <= 1'b1;
      else if (mcu_req) mcu_held <= 1'b0;
      cop_wait <= cop_held ? 0 : cop_wait + 1;
      mcu_wait <= mcu_held ? 0 : mcu_wait + 1;
    end
  end

  // ----------------------------------------
  // protocol rules
  // ----------------------------------------
  we_only_on_write: assert property (@(posedge CLK2) disable iff (!rst_n)
    !ram_we |-> ((state == st_cop_access) && (cop_op == op_write)) ||
                ((state == st_mcu_access) && (mcu_op == op_write)))
    else $error("ram_we low outside a granted write");

  cop_credit_pulse: assert property (@(posedge CLK2) disable iff (!rst_n)
    cop_credit |=> !cop_credit) else $error("cop credit longer than one cycle");
  mcu_credit_pulse: assert property (@(posedge CLK2) disable iff (!rst_n)
    mcu_credit |=> !mcu_credit) else $error("mcu credit longer than one cycle");

  cop_req_with_credit: assert property (@(posedge CLK2) disable iff (!rst_n)
    cop_req |-> cop_held) else $error("cop request without a credit");
  mcu_req_with_credit: assert property (@(posedge CLK2) disable iff (!rst_n)
    mcu_req |-> mcu_held) else $error("mcu request without a credit");

  // wait counts from the cycle after the request
  cop_latency: assert property (@(posedge CLK2) disable iff (!rst_n)
    !cop_held |-> (cop_wait < CYCLE_LEN + 20)) else $error("cop credit late");
  mcu_latency: assert property (@(posedge CLK2) disable iff (!rst_n)
    !mcu_held |-> (mcu_wait < CYCLE_LEN + 20)) else $error("mcu credit late");

endmodule

bind ram_arb_top ram_arb_sva #(
  .CYCLE_LEN (CYCLE_LEN)
) u_sva (
  .CLK2       (CLK2),
  .rst_n      (rst_n),
  .ram_we     (ram_we),
  .state      (u_ram_arbiter_fsm.state_q),
  .cop_op     (cop_bus.op),
  .mcu_op     (mcu_bus.op),
  .cop_req    (cop_req),
  .cop_credit (cop_credit),
  .mcu_req    (mcu_req),
  .mcu_credit (mcu_credit)
);

// File: verification/ram_arb_tb.sv
`timescale 1ns/1ps

module ram_arb_tb import mem_arb_pkg::*; ();

  localparam int unsigned CYCLE_LEN  = 5;
  localparam int unsigned SYNC_DEPTH = 7;
  localparam int unsigned n_rows     = 12;
  localparam int unsigned wait_limit = 200;  // per row, cycles

  typedef struct {
    string             name;
    bit                is_mcu;
    bit                wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    bit                hit;   // console holds save RAM
    bit                both;  // both requesters fire together
  } row_t;

  logic              CLK2;
  logic              rst_n;
  logic              snes_cpu_clk;
  logic              snes_ram_hit;
  logic              cop_req;
  logic              cop_write;
  logic [addr_w-1:0] cop_addr;
  logic [data_w-1:0] cop_wdata;
  logic              cop_credit;
  logic [data_w-1:0] cop_rdata;
  logic              mcu_req;
  logic              mcu_write;
  logic [addr_w-1:0] mcu_addr;
  logic [data_w-1:0] mcu_wdata;
  logic              mcu_credit;
  logic [data_w-1:0] mcu_rdata;
  logic [addr_w-1:0] ram_addr;
  logic [data_w-1:0] ram_wdata;
  logic              ram_we;
  logic [data_w-1:0] ram_rdata;

  logic [2:0]        cpu_cnt;
  logic [data_w-1:0] sram [0:(1 << addr_w) - 1];
  logic [data_w-1:0] sb [logic [addr_w-1:0]];  // written bytes only
  row_t              rows [$];
  int unsigned       errors;
  int unsigned       bad_tests;

  ram_arb_top #(
    .CYCLE_LEN  (CYCLE_LEN),
    .SYNC_DEPTH (SYNC_DEPTH)
  ) u_dut (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_ram_hit (snes_ram_hit),
    .cop_req      (cop_req),
    .cop_write    (cop_write),
    .cop_addr     (cop_addr),
    .cop_wdata    (cop_wdata),
    .cop_credit   (cop_credit),
    .cop_rdata    (cop_rdata),
    .mcu_req      (mcu_req),
    .mcu_write    (mcu_write),
    .mcu_addr     (mcu_addr),
    .mcu_wdata    (mcu_wdata),
    .mcu_credit   (mcu_credit),
    .mcu_rdata    (mcu_rdata),
    .ram_addr     (ram_addr),
    .ram_wdata    (ram_wdata),
    .ram_we       (ram_we),
    .ram_rdata    (ram_rdata)
  );

  // ----------------------------------------
  // clocks and SRAM model
  // ----------------------------------------
  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  always @(posedge CLK2) begin
    if (cpu_cnt == 3'd5) begin  // toggles every 6 cycles
      cpu_cnt      <= 3'd0;
      snes_cpu_clk <= ~snes_cpu_clk;
    end else begin
      cpu_cnt <= cpu_cnt + 3'd1;
    end
  end

  assign ram_rdata = sram[ram_addr];  // asynchronous read

  always @(posedge CLK2) begin
    if (!ram_we) begin
      sram[ram_addr] <= ram_wdata;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [data_w-1:0] fill_byte(input logic [addr_w-1:0] a);
    return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]};
  endfunction

  function automatic logic [data_w-1:0] expect_byte(input logic [addr_w-1:0] a);
    return sb.exists(a) ? sb[a] : fill_byte(a);
  endfunction

  task automatic add_row(input string name, input bit is_mcu, input bit wr,
                         input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                         input bit hit, input bit both);
    row_t r;
    r.name   = name;
    r.is_mcu = is_mcu;
    r.wr     = wr;
    r.addr   = addr;
    r.data   = data;
    r.hit    = hit;
    r.both   = both;
    rows.push_back(r);
  endtask

  task automatic check_byte(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] got);
    assert (got === exp) else begin
      $display("[ERROR] %s expected %02h actual %02h", name, exp, got);
      errors++;
    end
  endtask

  task automatic run_row(input row_t r);
    bit                use_cop;
    bit                use_mcu;
    bit                cop_seen;
    bit                mcu_seen;
    int unsigned       cop_t;
    int unsigned       mcu_t;
    int unsigned       own_t;
    int unsigned       fall_t;
    int unsigned       t;
    int unsigned       err_before;
    logic [addr_w-1:0] m_addr;
    logic [data_w-1:0] m_data;
    logic [data_w-1:0] cop_got;
    logic [data_w-1:0] mcu_got;
    use_cop    = r.both || !r.is_mcu;
    use_mcu    = r.both || r.is_mcu;
    m_addr     = r.both ? (r.addr ^ addr_w'(1)) : r.addr;  // neighbour byte for the mcu
    m_data     = r.both ? ~r.data : r.data;
    cop_got    = 'x;
    mcu_got    = 'x;
    cop_t      = 0;
    mcu_t      = 0;
    fall_t     = 0;
    err_before = errors;
    snes_ram_hit <= r.hit;
    // two cycles after a rising cpu clock edge, just ahead of its cycle-start slot
    @(posedge CLK2);
    while (!(cpu_cnt == 3'd1 && snes_cpu_clk == 1'b1)) @(posedge CLK2);
    if (use_cop) begin
      cop_req   <= 1'b1;
      cop_write <= r.wr;
      cop_addr  <= r.addr;
      cop_wdata <= r.data;
    end
    if (use_mcu) begin
      mcu_req   <= 1'b1;
      mcu_write <= r.wr;
      mcu_addr  <= m_addr;
      mcu_wdata <= m_data;
    end
    if (r.wr && use_cop) sb[r.addr] = r.data;
    if (r.wr && use_mcu) sb[m_addr] = m_data;
    @(posedge CLK2);
    cop_req <= 1'b0;  // one cycle only
    mcu_req <= 1'b0;
    cop_seen = !use_cop;
    mcu_seen = !use_mcu;
    t = 0;
    while (!(cop_seen && mcu_seen) && t < wait_limit) begin
      @(posedge CLK2);
      t++;
      if (fall_t == 0 && !snes_cpu_clk) begin
        fall_t = t;  // first cycle after the cycle end
      end
      if (cop_credit) begin
        cop_seen = 1'b1;
        cop_t    = t;
        cop_got  = cop_rdata;
      end
      if (mcu_credit) begin
        mcu_seen = 1'b1;
        mcu_t    = t;
        mcu_got  = mcu_rdata;
      end
    end
    assert (cop_seen && mcu_seen) else begin
      $display("%s: credit not returned within %0d cycles", r.name, wait_limit);
      errors++;
    end
    if (!r.wr && use_cop) check_byte(r.name, expect_byte(r.addr), cop_got);
    if (!r.wr && use_mcu) check_byte(r.name, expect_byte(m_addr), mcu_got);
    if (r.both) begin
      assert (cop_t < mcu_t) else begin
        $display("%s: coprocessor credit did not come before the mcu credit", r.name);
        errors++;
      end
    end
    // grant starts CYCLE_LEN+2 cycles ahead of the credit, after the cycle end
    if (r.hit && !r.both) begin
      own_t = r.is_mcu ? mcu_t : cop_t;
      assert (own_t > fall_t + CYCLE_LEN + 2) else begin
        $display("%s: access took a cycle-start slot while the console held save RAM",
                 r.name);
        errors++;
      end
    end
    if (errors != err_before) bad_tests++;
    $display("test %-18s %s", r.name, (errors == err_before) ? "ok" : "bad");
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    logic [addr_w-1:0] rnd_a;
    logic [addr_w-1:0] rnd_b;
    void'($urandom(22));
    rst_n        = 1'b0;
    snes_cpu_clk = 1'b0;
    snes_ram_hit = 1'b0;
    cpu_cnt      = 3'd0;
    cop_req      = 1'b0;
    cop_write    = 1'b0;
    cop_addr     = '0;
    cop_wdata    = '0;
    mcu_req      = 1'b0;
    mcu_write    = 1'b0;
    mcu_addr     = '0;
    mcu_wdata    = '0;
    errors       = 0;
    bad_tests    = 0;
    for (int unsigned a = 0; a < (1 << addr_w); a++) sram[addr_w'(a)] = fill_byte(addr_w'(a));
    rnd_a = addr_w'($urandom);
    rnd_b = addr_w'($urandom);
    //       name                 mcu   wr    addr       data                hit   both
    add_row("mcu_write",          1'b1, 1'b1, 19'h00123, 8'h5a,              1'b0, 1'b0);
    add_row("mcu_read_back",      1'b1, 1'b0, 19'h00123, 8'h00,              1'b0, 1'b0);
    add_row("cop_rnd_write",      1'b0, 1'b1, rnd_a,     data_w'($urandom),  1'b0, 1'b0);
    add_row("cop_rnd_read",       1'b0, 1'b0, rnd_a,     8'h00,              1'b0, 1'b0);
    add_row("both_write",         1'b0, 1'b1, 19'h40000, 8'hc3,              1'b0, 1'b1);
    add_row("both_read",          1'b0, 1'b0, 19'h40000, 8'h00,              1'b0, 1'b1);
    add_row("hit_cop_write",      1'b0, 1'b1, 19'h7ffff, 8'h81,              1'b1, 1'b0);
    add_row("hit_mcu_read",       1'b1, 1'b0, 19'h7ffff, 8'h00,              1'b1, 1'b0);
    add_row("hit_cop_read",       1'b0, 1'b0, 19'h40000, 8'h00,              1'b1, 1'b0);
    add_row("unwritten_read",     1'b1, 1'b0, 19'h2a5c1, 8'h00,              1'b0, 1'b0);
    add_row("hit_mcu_rnd_write",  1'b1, 1'b1, rnd_b,     data_w'($urandom),  1'b1, 1'b0);
    add_row("cop_rnd_read_back",  1'b0, 1'b0, rnd_b,     8'h00,              1'b0, 1'b0);

    repeat (2) @(posedge CLK2);
    rst_n <= 1'b1;
    @(posedge CLK2);
    assert (!cop_credit && !mcu_credit && ram_we) else begin
      $display("[ERROR] reset_state expected credits 00 we 1 actual credits %b%b we %b",
               cop_credit, mcu_credit, ram_we);
      errors++;
      bad_tests++;
    end
    $display("test %-18s %s", "reset_state", (errors == 0) ? "ok" : "bad");

    foreach (rows[i]) run_row(rows[i]);

    $display("tests %0d, bad tests %0d, errors %0d", rows.size() + 1, bad_tests, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (n_rows * 200) @(posedge CLK2);
    $display("watchdog: run did not finish within %0d cycles", n_rows * 200);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: compile.f
logic/mem_arb_pkg.sv
logic/slot_if.sv
logic/cycle_sync.sv
logic/request_slot.sv
logic/access_timer.sv
logic/ram_arbiter_fsm.sv
logic/ram_data_path.sv
logic/ram_arb_top.sv
verification/ram_arb_sva.sv
verification/ram_arb_tb.sv

// File: Makefile
# Verilator build and run of the save-RAM arbiter testbench

VERILATOR ?= verilator
TOP       ?= ram_arb_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
